// ==== Makefile ====
# Verilator build for the CSR block testbench

VERILATOR ?= verilator
TOP       ?= tb_csr_subsystem
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= SIMULATION PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# The run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
+incdir+.
csr_pkg.sv
mmio_req_if.sv
csr_rd_responder.sv
csr_wr_handler.sv
sreg_file.sv
csr_subsystem_top.sv
tb_csr_subsystem.sv

// ==== csr_defs.svh ====
/*
 Shared constants for the AFU CSR block.
 Local CSR indices count 8-byte words inside an 8-word window.
 The DFH fields are sized so that they can be concatenated directly.
 CSR_SREG_LATENCY must be at least 1.
*/
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Local CSR word indices
`define CSR_IDX_DFH          3'd0
`define CSR_IDX_ID_L         3'd1
`define CSR_IDX_ID_H         3'd2
`define CSR_IDX_SREG_ACCESS  3'd5
`define CSR_IDX_SREG_WDATA   3'd6

// Number of words in the local window, addresses at or above this are ignored
`define CSR_NUM_LOCAL        8

// DFH feature type, bits 63 to 60
`define CSR_DFH_TYPE_AFU     4'h1

// DFH next-header byte offset, bits 39 to 16
`define CSR_DFH_NEXT         24'h001000

// System register file geometry and read delay in cycles
`define CSR_SREG_COUNT       16
`define CSR_SREG_LATENCY     3

`endif

// ==== csr_pkg.sv ====
/*
 Types shared by the CSR block.
 The SREG selector width follows from the SREG count in the defines header,
 so the count must stay a power of two.
*/
`include "csr_defs.svh"

package csr_pkg;

    // MMIO address in 8-byte words
    typedef logic [7:0] mmio_addr_t;

    // One MMIO data word
    typedef logic [63:0] mmio_data_t;

    // Host transaction tag, returned unchanged with each read response
    typedef logic [8:0] mmio_tid_t;

    // Index inside the local CSR window
    typedef logic [2:0] csr_index_t;

    // Selects one system register
    typedef logic [$clog2(`CSR_SREG_COUNT)-1:0] sreg_index_t;

    // States of the delayed SREG read engine
    typedef enum logic
    {
        SREG_IDLE,
        SREG_WAIT
    } sreg_state_t;

endpackage

// ==== csr_rd_responder.sv ====
/*
 Host read decoder for the local CSR window.
 Local CSRs answer combinationally in the cycle of the request.
 A read of the SREG access word starts a delayed SREG read instead, and its
 response is sent later with the saved tag in a cycle with no local response.
 Only one SREG read may be outstanding, the host has to enforce this.
 Reads at address CSR_NUM_LOCAL and above get no response.
*/
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_rd_responder
#(
    parameter logic [127:0] AFU_ID = 128'h0
)
(
    input  logic                clk,
    input  logic                reset_n,
    mmio_req_if.sink            req,
    output logic                rd_rsp_valid,
    output csr_pkg::mmio_tid_t  rd_rsp_tid,
    output csr_pkg::mmio_data_t rd_rsp_data,
    output logic                sreg_rd_req,
    input  logic                sreg_rsp_valid,
    input  csr_pkg::mmio_data_t sreg_rsp_data
);

    // Feature header: type AFU, end of list at bit 40, next offset, rest zero
    localparam csr_pkg::mmio_data_t DFH_VALUE =
    {
        `CSR_DFH_TYPE_AFU,
        19'd0,
        1'b1,
        `CSR_DFH_NEXT,
        16'd0
    };

    // Read request that falls inside the local window
    logic                local_rd;
    // Local read that produces a response in this cycle
    logic                local_rsp;
    csr_pkg::csr_index_t rd_idx;

    // Held SREG response and the tag of the read that launched it
    logic                held_valid;
    csr_pkg::mmio_data_t held_data;
    csr_pkg::mmio_tid_t  sreg_tid;
    // High when the held response goes out in this cycle
    logic                held_emit;

    assign rd_idx   = req.addr[$bits(csr_pkg::csr_index_t)-1:0];
    assign local_rd = req.valid && !req.is_write && (req.addr < `CSR_NUM_LOCAL);

    // The access word does not answer directly, it launches the SREG read
    assign sreg_rd_req = local_rd && (rd_idx == `CSR_IDX_SREG_ACCESS);
    assign local_rsp   = local_rd && (rd_idx != `CSR_IDX_SREG_ACCESS);

    // Response mux, local reads win over a held SREG response
    always_comb
    begin
        rd_rsp_valid = 1'b0;
        rd_rsp_tid   = req.tid;
        rd_rsp_data  = '0;
        held_emit    = 1'b0;

        if (local_rsp)
        begin
            rd_rsp_valid = 1'b1;
            case (rd_idx)
                `CSR_IDX_DFH:
                begin
                    rd_rsp_data = DFH_VALUE;
                end
                `CSR_IDX_ID_L:
                begin
                    rd_rsp_data = AFU_ID[63:0];
                end
                `CSR_IDX_ID_H:
                begin
                    rd_rsp_data = AFU_ID[127:64];
                end
                default:
                begin
                    // Reserved words and the write-data port read as zero
                    rd_rsp_data = '0;
                end
            endcase
        end
        else if (held_valid)
        begin
            // Free slot, send the SREG data back with the tag of its read
            held_emit    = 1'b1;
            rd_rsp_valid = 1'b1;
            rd_rsp_tid   = sreg_tid;
            rd_rsp_data  = held_data;
        end
    end

    // Tag of the pending SREG read
    always_ff @(posedge clk)
    begin
        if (sreg_rd_req)
        begin
            sreg_tid <= req.tid;
        end
    end

    // The held flag clears once the response has gone out
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            held_valid <= 1'b0;
        end
        else if (held_emit)
        begin
            held_valid <= 1'b0;
        end
        else if (sreg_rsp_valid)
        begin
            held_valid <= 1'b1;
        end
    end

    // Data from the SREG file, kept until a slot is free
    always_ff @(posedge clk)
    begin
        if (sreg_rsp_valid)
        begin
            held_data <= sreg_rsp_data;
        end
    end

endmodule

// ==== csr_subsystem_top.sv ====
/*
 Top level of the AFU CSR block.
 Local CSR reads answer in the request cycle, SREG reads answer
 CSR_SREG_LATENCY+1 cycles later unless local reads take the response slot.
 Writes and reads outside the local window get no response.
 The host always accepts responses and keeps at most one SREG read pending.
*/
`timescale 1ns/1ns

module csr_subsystem_top
#(
    parameter logic [127:0] AFU_ID = 128'h0
)
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                req_valid,
    input  logic                req_is_write,
    input  csr_pkg::mmio_addr_t req_addr,
    input  csr_pkg::mmio_tid_t  req_tid,
    input  csr_pkg::mmio_data_t req_wdata,
    output logic                rd_rsp_valid,
    output csr_pkg::mmio_tid_t  rd_rsp_tid,
    output csr_pkg::mmio_data_t rd_rsp_data
);

    // Links between the decoders and the SREG file
    csr_pkg::sreg_index_t sreg_sel;
    logic                 sreg_wr_en;
    csr_pkg::mmio_data_t  sreg_wr_data;
    logic                 sreg_rd_req;
    logic                 sreg_rsp_valid;
    csr_pkg::mmio_data_t  sreg_rsp_data;

    // Host request channel, shared by both decoders
    mmio_req_if req_bus ();

    assign req_bus.valid    = req_valid;
    assign req_bus.is_write = req_is_write;
    assign req_bus.addr     = req_addr;
    assign req_bus.tid      = req_tid;
    assign req_bus.wdata    = req_wdata;

    csr_rd_responder #(
        .AFU_ID         (AFU_ID)
    ) csr_rd_responder_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .req            (req_bus),
        .rd_rsp_valid   (rd_rsp_valid),
        .rd_rsp_tid     (rd_rsp_tid),
        .rd_rsp_data    (rd_rsp_data),
        .sreg_rd_req    (sreg_rd_req),
        .sreg_rsp_valid (sreg_rsp_valid),
        .sreg_rsp_data  (sreg_rsp_data)
    );

    csr_wr_handler csr_wr_handler_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .req            (req_bus),
        .sreg_sel       (sreg_sel),
        .sreg_wr_en     (sreg_wr_en),
        .sreg_wr_data   (sreg_wr_data)
    );

    sreg_file sreg_file_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .sreg_sel       (sreg_sel),
        .sreg_wr_en     (sreg_wr_en),
        .sreg_wr_data   (sreg_wr_data),
        .sreg_rd_req    (sreg_rd_req),
        .sreg_rsp_valid (sreg_rsp_valid),
        .sreg_rsp_data  (sreg_rsp_data)
    );

endmodule

// ==== csr_wr_handler.sv ====
/*
 Host write decoder for the local CSR window.
 A write to the SREG access word selects the SREG from the low data bits.
 A write to the SREG write-data word writes the selected SREG one cycle later.
 Writes to all other words and to addresses outside the window are dropped.
*/
`timescale 1ns/1ns
`include "csr_defs.svh"

module csr_wr_handler
(
    input  logic                 clk,
    input  logic                 reset_n,
    mmio_req_if.sink             req,
    output csr_pkg::sreg_index_t sreg_sel,
    output logic                 sreg_wr_en,
    output csr_pkg::mmio_data_t  sreg_wr_data
);

    // Write request that falls inside the local window
    logic                local_wr;
    csr_pkg::csr_index_t wr_idx;

    assign wr_idx   = req.addr[$bits(csr_pkg::csr_index_t)-1:0];
    assign local_wr = req.valid && req.is_write && (req.addr < `CSR_NUM_LOCAL);

    // SREG selector and the write strobe
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            sreg_sel   <= '0;
            sreg_wr_en <= 1'b0;
        end
        else
        begin
            // The strobe is high for a single cycle per data write
            sreg_wr_en <= local_wr && (wr_idx == `CSR_IDX_SREG_WDATA);
            if (local_wr && (wr_idx == `CSR_IDX_SREG_ACCESS))
            begin
                sreg_sel <= req.wdata[$bits(csr_pkg::sreg_index_t)-1:0];
            end
        end
    end

    // Write payload, valid while sreg_wr_en is high
    always_ff @(posedge clk)
    begin
        if (local_wr && (wr_idx == `CSR_IDX_SREG_WDATA))
        begin
            sreg_wr_data <= req.wdata;
        end
    end

endmodule

// ==== mmio_req_if.sv ====
/*
 Host MMIO request channel.
 A request is present only in the cycle in which valid is high.
 There is no ready signal, so every sink must accept each request at once.
*/
`timescale 1ns/1ns

interface mmio_req_if;

    // Request qualifier, one cycle per request
    logic                 valid;
    // High for a write, low for a read
    logic                 is_write;
    // Word address of the access
    csr_pkg::mmio_addr_t  addr;
    // Tag that the read response has to carry back
    csr_pkg::mmio_tid_t   tid;
    // Write payload, don't care on reads
    csr_pkg::mmio_data_t  wdata;

    // Side that presents host requests
    modport source
    (
        output valid, is_write, addr, tid, wdata
    );

    // Side that decodes host requests
    modport sink
    (
        input valid, is_write, addr, tid, wdata
    );

endinterface

// ==== sreg_file.sv ====
/*
 System register file with a fixed-latency read engine.
 A read request at cycle t answers at t+CSR_SREG_LATENCY with a one-cycle
 sreg_rsp_valid, and the data shows the register as it is at that point.
 A read request while a read is pending is ignored.
*/
`timescale 1ns/1ns
`include "csr_defs.svh"

module sreg_file
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  csr_pkg::sreg_index_t sreg_sel,
    input  logic                 sreg_wr_en,
    input  csr_pkg::mmio_data_t  sreg_wr_data,
    input  logic                 sreg_rd_req,
    output logic                 sreg_rsp_valid,
    output csr_pkg::mmio_data_t  sreg_rsp_data
);

    localparam int CNT_W = $clog2(`CSR_SREG_LATENCY + 1);

    // Count loaded on a request, the response leaves when it reaches zero
    localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`CSR_SREG_LATENCY - 1);

    csr_pkg::mmio_data_t  regs [`CSR_SREG_COUNT];
    csr_pkg::sreg_state_t state;
    logic [CNT_W-1:0]     count;
    // Register chosen when the read was accepted
    csr_pkg::sreg_index_t rd_sel;

    // Register array, all registers come out of reset as zero
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < `CSR_SREG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (sreg_wr_en)
        begin
            regs[sreg_sel] <= sreg_wr_data;
        end
    end

    // Read engine
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= csr_pkg::SREG_IDLE;
            count <= '0;
        end
        else
        begin
            case (state)
                csr_pkg::SREG_IDLE:
                begin
                    if (sreg_rd_req)
                    begin
                        state <= csr_pkg::SREG_WAIT;
                        count <= CNT_LOAD;
                    end
                end
                csr_pkg::SREG_WAIT:
                begin
                    if (count == '0)
                    begin
                        state <= csr_pkg::SREG_IDLE;
                    end
                    else
                    begin
                        count <= count - CNT_W'(1);
                    end
                end
                default:
                begin
                    state <= csr_pkg::SREG_IDLE;
                end
            endcase
        end
    end

    // The selector is captured only when a read is accepted
    always_ff @(posedge clk)
    begin
        if ((state == csr_pkg::SREG_IDLE) && sreg_rd_req)
        begin
            rd_sel <= sreg_sel;
        end
    end

    // Sampled at expiry, so writes issued during the wait are visible
    assign sreg_rsp_valid = (state == csr_pkg::SREG_WAIT) && (count == '0);
    assign sreg_rsp_data  = regs[rd_sel];

endmodule

// ==== tb_csr_subsystem.sv ====
/*
 Directed testbench for the AFU CSR block.
 Inputs change 1 ns after the rising edge, outputs are sampled 3 ns after it.
 The SREG model tracks the selector and every data write issued by the tasks.
 Any mismatch or timeout stops the run at once.
*/
`timescale 1ns/1ns
`include "csr_defs.svh"

module tb_csr_subsystem;

    localparam logic [127:0] TB_AFU_ID = 128'hc0de_5a17_0042_9b3e_7710_e4a2_d1f0_6b85;
    localparam logic [7:0]   LOCAL_LIMIT = 8'(`CSR_NUM_LOCAL);
    localparam int           SREG_TIMEOUT = 20;

    logic        clk;
    logic        reset_n;
    logic        req_valid;
    logic        req_is_write;
    logic [7:0]  req_addr;
    logic [8:0]  req_tid;
    logic [63:0] req_wdata;
    logic        rd_rsp_valid;
    logic [8:0]  rd_rsp_tid;
    logic [63:0] rd_rsp_data;

    // LCG state and the expected SREG contents
    logic [31:0] rand_state;
    logic [63:0] model_sreg [`CSR_SREG_COUNT];
    logic [3:0]  model_sel;

    csr_subsystem_top #(
        .AFU_ID       (TB_AFU_ID)
    ) csr_subsystem_top_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .req_valid    (req_valid),
        .req_is_write (req_is_write),
        .req_addr     (req_addr),
        .req_tid      (req_tid),
        .req_wdata    (req_wdata),
        .rd_rsp_valid (rd_rsp_valid),
        .rd_rsp_tid   (rd_rsp_tid),
        .rd_rsp_data  (rd_rsp_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [63:0] random_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi, lo};
    endfunction

    // Header layout: type in 63:60, end of list at 40, next offset in 39:16
    function automatic logic [63:0] expected_dfh();
        logic [63:0] dfh;
        dfh = '0;
        dfh[63:60] = `CSR_DFH_TYPE_AFU;
        dfh[40] = 1'b1;
        dfh[39:16] = `CSR_DFH_NEXT;
        return dfh;
    endfunction

    function automatic logic [63:0] expected_local(input logic [2:0] idx);
        case (idx)
            3'd0: return expected_dfh();
            3'd1: return TB_AFU_ID[63:0];
            3'd2: return TB_AFU_ID[127:64];
            default: return 64'd0;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [63:0] actual,
                                 input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("FAILED: %s is 0x%h, expected 0x%h", name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped on a timeout");
    endtask

    // Moves to the drive point of the next cycle
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_request(input logic valid, input logic is_write,
                                 input logic [7:0] addr, input logic [8:0] tid,
                                 input logic [63:0] wdata);
        req_valid    = valid;
        req_is_write = is_write;
        req_addr     = addr;
        req_tid      = tid;
        req_wdata    = wdata;
    endtask

    task automatic drive_idle();
        drive_request(1'b0, 1'b0, 8'd0, 9'd0, 64'd0);
    endtask

    task automatic expect_no_response(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            #2;
            compare_value("rd_rsp_valid", 64'(rd_rsp_valid), 64'd0);
            next_cycle();
        end
    endtask

    task automatic host_write(input logic [7:0] addr, input logic [63:0] data);
        logic [31:0] r;
        r = next_random();
        drive_request(1'b1, 1'b1, addr, r[8:0], data);
        #2;
        compare_value("rd_rsp_valid", 64'(rd_rsp_valid), 64'd0);
        // Writes outside the window leave the model alone
        if ((addr < LOCAL_LIMIT) && (addr[2:0] == 3'd5))
        begin
            model_sel = data[3:0];
        end
        else if ((addr < LOCAL_LIMIT) && (addr[2:0] == 3'd6))
        begin
            model_sreg[model_sel] = data;
        end
        next_cycle();
        drive_idle();
    endtask

    // Leaves the bus idle, so a following call can issue back-to-back
    task automatic host_read_local(input logic [2:0] idx);
        logic [31:0] r;
        r = next_random();
        drive_request(1'b1, 1'b0, {5'd0, idx}, r[8:0], 64'(r));
        #2;
        compare_value("rd_rsp_valid", 64'(rd_rsp_valid), 64'd1);
        compare_value("rd_rsp_tid", 64'(rd_rsp_tid), 64'(r[8:0]));
        compare_value("rd_rsp_data", rd_rsp_data, expected_local(idx));
        next_cycle();
        drive_idle();
    endtask

    task automatic host_read_outside(input logic [7:0] addr);
        logic [31:0] r;
        r = next_random();
        drive_request(1'b1, 1'b0, addr, r[8:0], 64'd0);
        #2;
        compare_value("rd_rsp_valid", 64'(rd_rsp_valid), 64'd0);
        next_cycle();
        drive_idle();
        expect_no_response(4);
    endtask

    task automatic start_sreg_read(output logic [8:0] tid);
        logic [31:0] r;
        r = next_random();
        tid = r[8:0];
        drive_request(1'b1, 1'b0, 8'd5, tid, 64'd0);
        #2;
        // No response in the request cycle for the access word
        compare_value("rd_rsp_valid", 64'(rd_rsp_valid), 64'd0);
        next_cycle();
        drive_idle();
    endtask

    // Counts cycles from the one after the request until the response
    task automatic await_sreg_response(input logic [8:0] tid, input logic [63:0] data,
                                       output int cycles);
        logic seen;
        seen = 1'b0;
        cycles = 0;
        while (!seen && (cycles < SREG_TIMEOUT))
        begin
            cycles++;
            #2;
            if (rd_rsp_valid)
            begin
                seen = 1'b1;
            end
            else
            begin
                next_cycle();
            end
        end
        if (!seen)
        begin
            report_timeout("no response to the SREG read");
        end
        else
        begin
            compare_value("rd_rsp_tid", 64'(rd_rsp_tid), 64'(tid));
            compare_value("rd_rsp_data", rd_rsp_data, data);
            next_cycle();
        end
    endtask

    task automatic host_read_sreg();
        logic [8:0] tid;
        int         cycles;
        start_sreg_read(tid);
        await_sreg_response(tid, model_sreg[model_sel], cycles);
        compare_value("sreg read latency", 64'(cycles), 64'(`CSR_SREG_LATENCY + 1));
    endtask

    task automatic idle_and_dfh();
        expect_no_response(8);
        host_read_local(3'd0);
    endtask

    task automatic afu_id_and_reserved();
        host_read_local(3'd1);
        host_read_local(3'd2);
        host_read_local(3'd3);
        host_read_local(3'd4);
        host_read_local(3'd6);
        host_read_local(3'd7);
    endtask

    task automatic silent_requests();
        logic [31:0] r;
        for (int i = 0; i < 8; i++)
        begin
            host_write(8'(i), random_word());
            expect_no_response(3);
        end
        host_read_outside(8'd8);
        host_read_outside(8'hff);
        // Low bits match the access word, so a missing window check would launch a read
        host_read_outside(8'd13);
        for (int i = 0; i < 4; i++)
        begin
            r = next_random();
            host_read_outside(8'd8 + 8'(r % 32'd248));
        end
        // Aliases of the SREG words above the window must not reach the SREG file
        host_write(8'd13, random_word());
        expect_no_response(3);
        host_write(8'd14, random_word());
        expect_no_response(3);
        // The data written through index 6 above must be readable
        host_read_sreg();
    endtask

    task automatic random_sreg_access();
        logic [63:0] sel_word;
        for (int i = 0; i < 12; i++)
        begin
            // Upper bits of the selector write are noise and must be ignored
            sel_word = random_word();
            host_write(8'd5, sel_word);
            host_write(8'd6, random_word());
            host_read_sreg();
            // A select with no data write reads back whatever that SREG holds
            host_write(8'd5, random_word());
            host_read_sreg();
        end
    endtask

    task automatic sreg_behind_local_reads();
        logic [8:0]  tid;
        logic [31:0] r;
        logic [2:0]  idx;
        int          cycles;
        host_write(8'd5, random_word());
        host_write(8'd6, random_word());
        start_sreg_read(tid);
        // Six local reads cover the cycle in which the SREG data comes back
        for (int i = 0; i < 6; i++)
        begin
            r = next_random();
            idx = r[2:0];
            if (idx == 3'd5)
            begin
                idx = 3'd7;
            end
            host_read_local(idx);
        end
        await_sreg_response(tid, model_sreg[model_sel], cycles);
        compare_value("held response delay", 64'(cycles), 64'd1);
    endtask

    initial
    begin
        rand_state = 32'ha7f24f4d;
        reset_n = 1'b0;
        drive_idle();
        for (int i = 0; i < `CSR_SREG_COUNT; i++)
        begin
            model_sreg[i] = 64'd0;
        end
        model_sel = 4'd0;
        repeat (16) @(posedge clk);
        #1;
        reset_n = 1'b1;

        idle_and_dfh();
        afu_id_and_reserved();
        silent_requests();
        random_sreg_access();
        sreg_behind_local_reads();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
